// File: bench/frep_sequencer_sva.sv
/*
 * FREP sequencer protocol assertions
 * Bound into the top level, checks output handshake and issue priority
 */
`timescale 1ns/1ps
`default_nettype none

module frep_sequencer_sva #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input logic [frep_pkg::IdWidth-1:0]   oup_qid_i,
  input logic [frep_pkg::InstWidth-1:0] oup_op_i,
  input logic [DataWidth-1:0]           oup_arga_i,
  input logic [DataWidth-1:0]           oup_argb_i,
  input logic [AddrWidth-1:0]           oup_argc_i,
  input logic                           oup_repd_i,
  input logic                           oup_valid_i,
  input logic                           oup_ready_i,
  // Internal issue signals
  input logic                           direct_valid_i,
  input logic                           direct_ready_i,
  // Ring buffer holds no entry
  input logic                           rb_empty_i
);

  // Stalled output holds valid and payload
  property output_held;
    @(posedge clk_i) disable iff (!arst_n_i)
    oup_valid_i && !oup_ready_i |=> oup_valid_i &&
      $stable({oup_qid_i, oup_op_i, oup_arga_i, oup_argb_i, oup_argc_i, oup_repd_i});
  endproperty

  assert property (output_held)
    else $error("Output changed while stalled by back-pressure");

  // Nothing issued while reset is applied
  assert property (@(posedge clk_i) !arst_n_i |-> !oup_valid_i)
    else $error("Output valid during reset");

  // Direct path waits until every buffered instruction has gone out
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    direct_valid_i && direct_ready_i |-> rb_empty_i)
    else $error("Direct handshake while the buffer still held instructions");

endmodule

bind frep_sequencer frep_sequencer_sva #(
  .DataWidth (DataWidth),
  .AddrWidth (AddrWidth)
) frep_sequencer_sva_inst (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .oup_qid_i      (oup_qid_o),
  .oup_op_i       (oup_qdata_op_o),
  .oup_arga_i     (oup_qdata_arga_o),
  .oup_argb_i     (oup_qdata_argb_o),
  .oup_argc_i     (oup_qdata_argc_o),
  .oup_repd_i     (oup_qdata_repd_o),
  .oup_valid_i    (oup_qvalid_o),
  .oup_ready_i    (oup_qready_i),
  .direct_valid_i (direct_valid),
  .direct_ready_i (direct_ready),
  .rb_empty_i     (frep_ring_buffer_inst.fill == '0)
);

`default_nettype wire

// File: bench/tb_frep_sequencer.sv
/*
 * FREP sequencer testbench
 * Random program of buffered, direct and FREP instructions against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_frep_sequencer;

  localparam int unsigned BufferDepth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int ClkPeriod = 100;
  localparam int NumSegments = 60;

  // One instruction, as sent or as expected at the output
  typedef struct packed {
    logic [4:0]  id;
    logic [31:0] op;
    logic [31:0] arga;
    logic [31:0] argb;
    logic [31:0] argc;
    logic        repd;
  } item_t;

  logic clk;
  logic arst_n;
  logic [4:0] inp_qid, oup_qid;
  logic [31:0] inp_qdata_op, inp_qdata_arga, inp_qdata_argb, inp_qdata_argc;
  logic [31:0] oup_qdata_op, oup_qdata_arga, oup_qdata_argb, oup_qdata_argc;
  logic inp_qvalid, inp_qready;
  logic oup_qdata_repd, oup_qvalid, oup_qready;

  integer seed;
  int errors;
  int recv_cnt;
  int exp_total;
  int watchdog_cycles;
  logic [255:0] stall_pattern;
  item_t prog_q[$];
  // Expected output count to wait for before an input, -1 for none
  int wait_q[$];
  item_t exp_q[$];

  frep_sequencer #(
    .BufferDepth (BufferDepth),
    .DataWidth   (DataWidth),
    .AddrWidth   (AddrWidth)
  ) frep_sequencer_inst (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .inp_qid_i        (inp_qid),
    .inp_qdata_op_i   (inp_qdata_op),
    .inp_qdata_arga_i (inp_qdata_arga),
    .inp_qdata_argb_i (inp_qdata_argb),
    .inp_qdata_argc_i (inp_qdata_argc),
    .inp_qvalid_i     (inp_qvalid),
    .inp_qready_o     (inp_qready),
    .oup_qid_o        (oup_qid),
    .oup_qdata_op_o   (oup_qdata_op),
    .oup_qdata_arga_o (oup_qdata_arga),
    .oup_qdata_argb_o (oup_qdata_argb),
    .oup_qdata_argc_o (oup_qdata_argc),
    .oup_qdata_repd_o (oup_qdata_repd),
    .oup_qvalid_o     (oup_qvalid),
    .oup_qready_i     (oup_qready)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // CSR access or OP-FP move, compare or conversion
  function automatic bit is_direct_op(input logic [31:0] op);
    logic [4:0] f5;
    f5 = op[31:27];
    if (op[6:0] == 7'b1110011) begin
      return 1'b1;
    end
    return (op[6:0] == 7'b1010011) && (f5 == 5'b10100 || f5 == 5'b11000 ||
           f5 == 5'b11010 || f5 == 5'b11100 || f5 == 5'b11110);
  endfunction

  // Any op that neither decodes as FREP nor as direct
  function automatic logic [31:0] rand_buffered_op();
    logic [31:0] op;
    op = $random(seed);
    // Pull in OP-FP often to exercise the funct5 rule
    if (op[1:0] == 2'b00) begin
      op[6:0] = 7'b1010011;
    end
    if (op[6:0] == 7'b0001011 || is_direct_op(op)) begin
      op[6:0] = 7'b1000011;
    end
    return op;
  endfunction

  function automatic logic [31:0] rand_direct_op();
    logic [31:0] op;
    logic [31:0] sel;
    op = $random(seed);
    sel = $random(seed);
    case (sel[2:0])
      3'd1: op = {5'b10100, op[26:7], 7'b1010011};
      3'd2: op = {5'b11000, op[26:7], 7'b1010011};
      3'd3: op = {5'b11010, op[26:7], 7'b1010011};
      3'd4: op = {5'b11100, op[26:7], 7'b1010011};
      3'd5: op = {5'b11110, op[26:7], 7'b1010011};
      default: op[6:0] = 7'b1110011;
    endcase
    return op;
  endfunction

  // Register offset per masked field, wraps at 32
  function automatic logic [31:0] stagger_op(input logic [31:0] op, input logic [3:0] mask,
                                             input logic [4:0] offs);
    logic [31:0] res;
    res = op;
    if (mask[0]) res[11:7] = op[11:7] + offs;
    if (mask[1]) res[19:15] = op[19:15] + offs;
    if (mask[2]) res[24:20] = op[24:20] + offs;
    if (mask[3]) res[31:27] = op[31:27] + offs;
    return res;
  endfunction

  function automatic item_t rand_item(input logic [31:0] op);
    item_t it;
    it.id   = 5'($random(seed));
    it.op   = op;
    it.arga = $random(seed);
    it.argb = $random(seed);
    it.argc = $random(seed);
    it.repd = 1'b0;
    return it;
  endfunction

  // Sequenced issue carries no id and no operands a and b
  function automatic item_t seq_item(input logic [31:0] op, input logic [31:0] argc,
                                     input logic repd);
    return '{id: '0, op: op, arga: '0, argb: '0, argc: argc, repd: repd};
  endfunction

  // Random program and its expanded output stream
  task automatic build_program();
    item_t it;
    item_t body[$];
    int kind;
    int len;
    int n_iter;
    logic [3:0] m_inst;
    logic [2:0] s_max;
    logic [3:0] mask;
    for (int seg = 0; seg < NumSegments; seg++) begin
      kind = $unsigned($random(seed)) % 10;
      if (kind < 5) begin
        len = 1 + $unsigned($random(seed)) % 6;
        for (int i = 0; i < len; i++) begin
          it = rand_item(rand_buffered_op());
          prog_q.push_back(it);
          wait_q.push_back(-1);
          exp_q.push_back(seq_item(it.op, it.argc, 1'b0));
        end
      end else if (kind < 7) begin
        // Direct goes out unchanged once all earlier issues are done
        it = rand_item(rand_direct_op());
        prog_q.push_back(it);
        wait_q.push_back(exp_q.size());
        exp_q.push_back(it);
      end else begin
        m_inst = 4'($random(seed));
        n_iter = $unsigned($random(seed)) % 6;
        s_max = 3'($random(seed));
        mask = 4'($random(seed));
        it = rand_item($random(seed));
        it.op[23:20] = m_inst;
        it.op[14:12] = s_max;
        it.op[11:8] = mask;
        it.op[6:0] = 7'b0001011;
        it.arga = {16'($random(seed)), 16'(n_iter)};
        prog_q.push_back(it);
        wait_q.push_back(-1);
        body.delete();
        for (int i = 0; i <= int'(m_inst); i++) begin
          it = rand_item(rand_buffered_op());
          body.push_back(it);
          prog_q.push_back(it);
          wait_q.push_back(-1);
        end
        for (int k = 0; k <= n_iter; k++) begin
          foreach (body[i]) begin
            exp_q.push_back(seq_item(stagger_op(body[i].op, mask, 5'(k % (s_max + 1))),
                                     body[i].argc, k != 0));
          end
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driver and monitor
  ////////////////////////////////////////////////////////////

  // Starts on a falling edge, holds until accepted
  task automatic send_inst(input item_t it);
    logic accepted;
    accepted = 1'b0;
    inp_qid = it.id;
    inp_qdata_op = it.op;
    inp_qdata_arga = it.arga;
    inp_qdata_argb = it.argb;
    inp_qdata_argc = it.argc;
    inp_qvalid = 1'b1;
    while (!accepted) begin
      #(ClkPeriod / 4);
      accepted = inp_qready;
      @(negedge clk);
    end
    inp_qvalid = 1'b0;
  endtask

  task automatic wait_drained(input int count);
    while (recv_cnt != count) @(negedge clk);
  endtask

  task automatic check_output();
    item_t want;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Output at %0t ns with nothing expected, op %h", $time, oup_qdata_op);
    end else begin
      want = exp_q.pop_front();
      assert (oup_qdata_op == want.op && oup_qdata_argc == want.argc)
        else begin
          errors++;
          $display("[FAIL] %0t ns: output %0d op %h argc %h, expected op %h argc %h",
                   $time, recv_cnt, oup_qdata_op, oup_qdata_argc, want.op, want.argc);
        end
      assert (oup_qid == want.id && oup_qdata_arga == want.arga && oup_qdata_argb == want.argb)
        else begin
          errors++;
          $display("[FAIL] %0t ns: output %0d id/arga/argb %h/%h/%h, expected %h/%h/%h",
                   $time, recv_cnt, oup_qid, oup_qdata_arga, oup_qdata_argb,
                   want.id, want.arga, want.argb);
        end
      assert (oup_qdata_repd == want.repd)
        else begin
          errors++;
          $display("[FAIL] %0t ns: output %0d repd %b, expected %b",
                   $time, recv_cnt, oup_qdata_repd, want.repd);
        end
      recv_cnt++;
    end
  endtask

  // Random back-pressure, ready about three cycles in four
  initial begin
    int cyc;
    cyc = 0;
    forever begin
      @(negedge clk);
      oup_qready = stall_pattern[cyc % 256] || stall_pattern[(cyc + 97) % 256];
      cyc++;
      #(ClkPeriod / 4);
      if (arst_n && oup_qvalid && oup_qready) check_output();
    end
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: %0d of %0d outputs seen after %0d cycles",
             recv_cnt, exp_total, watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed = 32'h2a99_16cb;
    errors = 0;
    recv_cnt = 0;
    watchdog_cycles = 0;
    clk = 1'b0;
    arst_n = 1'b0;
    inp_qid = '0;
    inp_qdata_op = '0;
    inp_qdata_arga = '0;
    inp_qdata_argb = '0;
    inp_qdata_argc = '0;
    inp_qvalid = 1'b0;
    oup_qready = 1'b0;
    build_program();
    for (int i = 0; i < 8; i++) begin
      stall_pattern[i*32 +: 32] = $random(seed);
    end
    exp_total = exp_q.size();
    watchdog_cycles = exp_total * 20 + prog_q.size() * 4 + 500;

    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    foreach (prog_q[i]) begin
      if (wait_q[i] >= 0) wait_drained(wait_q[i]);
      send_inst(prog_q[i]);
    end
    wait_drained(exp_total);
    // Idle tail catches repeated issues
    repeat (20) @(negedge clk);

    $display("Sent %0d, checked %0d of %0d outputs, errors %0d",
             prog_q.size(), recv_cnt, exp_total, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/frep_decoder.sv
/*
 * FREP decoder
 * Classifies instructions and splits the input handshake into three paths
 */
`timescale 1ns/1ps
`default_nettype none

module frep_decoder (
  input  logic [frep_pkg::InstWidth-1:0] inp_qdata_op_i,
  input  logic                           inp_qvalid_i,
  output logic                           inp_qready_o,
  // Buffer write path
  output logic                           rb_wvalid_o,
  input  logic                           rb_wready_i,
  // FREP path
  output logic                           frep_valid_o,
  input  logic                           frep_ready_i,
  output frep_pkg::frep_cfg_t            frep_cfg_o,
  // Direct path
  output logic                           direct_valid_o,
  input  logic                           direct_ready_i
);

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic is_direct_fp;
  frep_pkg::inst_path_e path_sel;

  assign opcode = inp_qdata_op_i[6:0];
  assign funct5 = inp_qdata_op_i[31:27];

  ////////////////////////////////////////////////////////////
  // Path classification
  ////////////////////////////////////////////////////////////

  // OP-FP moves, compares and conversions between int and float
  always_comb begin
    is_direct_fp = 1'b0;
    for (int i = 0; i < frep_pkg::NumDirectFunct5; i++) begin
      if (funct5 == frep_pkg::DirectFunct5List[i]) begin
        is_direct_fp = 1'b1;
      end
    end
  end

  always_comb begin
    path_sel = frep_pkg::PathBuffer;
    if (opcode == frep_pkg::OpcodeFrep) begin
      path_sel = frep_pkg::PathFrep;
    end else if (opcode == frep_pkg::OpcodeSystem) begin
      // CSR accesses
      path_sel = frep_pkg::PathDirect;
    end else if (opcode == frep_pkg::OpcodeOpFp && is_direct_fp) begin
      path_sel = frep_pkg::PathDirect;
    end
  end

  ////////////////////////////////////////////////////////////
  // Input demux
  ////////////////////////////////////////////////////////////

  // Valid goes to the selected path only
  assign rb_wvalid_o    = inp_qvalid_i && (path_sel == frep_pkg::PathBuffer);
  assign frep_valid_o   = inp_qvalid_i && (path_sel == frep_pkg::PathFrep);
  assign direct_valid_o = inp_qvalid_i && (path_sel == frep_pkg::PathDirect);

  always_comb begin
    case (path_sel)
      frep_pkg::PathFrep:   inp_qready_o = frep_ready_i;
      frep_pkg::PathDirect: inp_qready_o = direct_ready_i;
      default:              inp_qready_o = rb_wready_i;
    endcase
  end

  // Stagger fields; iteration count comes from arga at the top
  assign frep_cfg_o.max_iter     = '0;
  assign frep_cfg_o.stagger_max  = inp_qdata_op_i[frep_pkg::StaggerMaxLsb +: 3];
  assign frep_cfg_o.stagger_mask = inp_qdata_op_i[frep_pkg::StaggerMaskLsb +: 4];

endmodule

`default_nettype wire

// File: rtl/frep_if.sv
/*
 * FREP sequencer internal interfaces
 * Ring buffer read side and sequenced issue stream
 */
`timescale 1ns/1ps
`default_nettype none

// Ring buffer read side, random access from the loop controller
interface frep_rb_if #(
  parameter int unsigned DepthBits = 4,
  parameter int unsigned EntryWidth = 64
);

  // Controller side
  logic [DepthBits-1:0]  raddr;
  logic                  advance;
  logic [DepthBits:0]    step;

  // Buffer side
  logic [EntryWidth-1:0] rdata;
  logic                  rvalid;
  logic [DepthBits-1:0]  wptr;

  modport buffer (
    input  raddr, advance, step,
    output rdata, rvalid, wptr
  );

  modport ctrl (
    output raddr, advance, step,
    input  rdata, rvalid, wptr
  );

endinterface

// Sequenced instruction stream, valid/ready handshake
interface frep_seq_if #(
  parameter int unsigned AddrWidth = 32
);

  logic                           valid;
  logic                           ready;
  logic [frep_pkg::InstWidth-1:0] op;
  logic [AddrWidth-1:0]           argc;
  // Repeated issue marker
  logic                           repd;

  modport src (
    output valid, op, argc, repd,
    input  ready
  );

  modport dst (
    input  valid, op, argc, repd,
    output ready
  );

endinterface

`default_nettype wire

// File: rtl/frep_issue_mux.sv
/*
 * FREP issue mux
 * Sequenced stream has priority, direct path only when the buffer is drained
 */
`timescale 1ns/1ps
`default_nettype none

module frep_issue_mux #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  frep_seq_if.dst                        seq,
  // Direct path
  input  logic                           direct_valid_i,
  output logic                           direct_ready_o,
  input  logic [frep_pkg::IdWidth-1:0]   inp_qid_i,
  input  logic [frep_pkg::InstWidth-1:0] inp_qdata_op_i,
  input  logic [DataWidth-1:0]           inp_qdata_arga_i,
  input  logic [DataWidth-1:0]           inp_qdata_argb_i,
  input  logic [AddrWidth-1:0]           inp_qdata_argc_i,
  // Output stream
  output logic [frep_pkg::IdWidth-1:0]   oup_qid_o,
  output logic [frep_pkg::InstWidth-1:0] oup_qdata_op_o,
  output logic [DataWidth-1:0]           oup_qdata_arga_o,
  output logic [DataWidth-1:0]           oup_qdata_argb_o,
  output logic [AddrWidth-1:0]           oup_qdata_argc_o,
  output logic                           oup_qdata_repd_o,
  output logic                           oup_qvalid_o,
  input  logic                           oup_qready_i
);

  // Sequenced valid means the buffer has something to issue
  assign oup_qvalid_o   = seq.valid || direct_valid_i;
  assign seq.ready      = oup_qready_i;
  assign direct_ready_o = oup_qready_i && !seq.valid;

  // Sequenced issues carry no id or operands
  assign oup_qid_o        = seq.valid ? '0 : inp_qid_i;
  assign oup_qdata_op_o   = seq.valid ? seq.op : inp_qdata_op_i;
  assign oup_qdata_arga_o = seq.valid ? '0 : inp_qdata_arga_i;
  assign oup_qdata_argb_o = seq.valid ? '0 : inp_qdata_argb_i;
  assign oup_qdata_argc_o = seq.valid ? seq.argc : inp_qdata_argc_i;
  assign oup_qdata_repd_o = seq.valid && seq.repd;

endmodule

`default_nettype wire

// File: rtl/frep_loop_ctrl.sv
/*
 * FREP loop controller
 * Single-level hardware loop over the ring buffer with register staggering
 */
`timescale 1ns/1ps
`default_nettype none

module frep_loop_ctrl #(
  parameter int unsigned DepthBits = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 frep_valid_i,
  input  frep_pkg::frep_cfg_t  frep_cfg_i,
  input  logic [DepthBits-1:0] frep_max_inst_i,
  output logic                 frep_ready_o,
  frep_rb_if.ctrl              rb,
  frep_seq_if.src              seq
);

  // Loop configuration
  frep_pkg::frep_cfg_t cfg_q;
  logic [DepthBits-1:0] max_inst_q;
  logic [DepthBits-1:0] base_q, base_d;

  // Loop state
  logic configured_q, configured_d;
  logic active_q, active_d;
  // Read pointer a whole lap behind the loop base
  logic lap_q, lap_d;
  logic [DepthBits-1:0] rd_ptr_q, rd_ptr_d;
  logic [DepthBits-1:0] inst_cnt_q, inst_cnt_d;
  logic [frep_pkg::LoopIterBits-1:0] iter_cnt_q, iter_cnt_d;
  logic [2:0] stagger_q, stagger_d;

  logic frep_hs, seq_hs;
  logic last_inst, last_iter, loop_end;
  logic [frep_pkg::InstWidth-1:0] raw_op;

  // Only one loop at a time
  assign frep_ready_o = !configured_q;
  assign frep_hs      = frep_valid_i && frep_ready_o;
  assign seq_hs       = seq.valid && seq.ready;

  assign last_inst = inst_cnt_q == max_inst_q;
  assign last_iter = iter_cnt_q == cfg_q.max_iter;
  assign loop_end  = active_q && seq_hs && last_inst && last_iter;

  // Loop body starts at the next buffer write
  assign base_d = frep_hs ? rb.wptr : base_q;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    configured_d = configured_q;
    active_d     = active_q;
    lap_d        = lap_q;
    rd_ptr_d     = rd_ptr_q;
    inst_cnt_d   = inst_cnt_q;
    iter_cnt_d   = iter_cnt_q;
    stagger_d    = stagger_q;

    if (frep_hs) begin
      configured_d = 1'b1;
      stagger_d    = '0;
      // Buffer full of older entries
      lap_d        = rb.rvalid && (rd_ptr_q == rb.wptr);
    end

    if (seq_hs) begin
      lap_d    = 1'b0;
      rd_ptr_d = rd_ptr_q + 1'b1;
      if (active_q) begin
        inst_cnt_d = inst_cnt_q + 1'b1;
        if (last_inst) begin
          inst_cnt_d = '0;
          if (last_iter) begin
            // Loop done, counters back to idle
            iter_cnt_d   = '0;
            stagger_d    = '0;
            configured_d = 1'b0;
          end else begin
            // Wrap back to the loop body
            iter_cnt_d = iter_cnt_q + 1'b1;
            rd_ptr_d   = base_q;
            stagger_d  = (stagger_q == cfg_q.stagger_max) ? '0 : stagger_q + 1'b1;
          end
        end
      end
    end

    // Active once all earlier instructions have gone out
    if (loop_end) begin
      active_d = 1'b0;
    end else if (configured_d && !lap_d && (rd_ptr_d == base_d)) begin
      active_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q        <= '0;
      max_inst_q   <= '0;
      base_q       <= '0;
      configured_q <= 1'b0;
      active_q     <= 1'b0;
      lap_q        <= 1'b0;
      rd_ptr_q     <= '0;
      inst_cnt_q   <= '0;
      iter_cnt_q   <= '0;
      stagger_q    <= '0;
    end else begin
      if (frep_hs) begin
        cfg_q      <= frep_cfg_i;
        max_inst_q <= frep_max_inst_i;
      end
      base_q       <= base_d;
      configured_q <= configured_d;
      active_q     <= active_d;
      lap_q        <= lap_d;
      rd_ptr_q     <= rd_ptr_d;
      inst_cnt_q   <= inst_cnt_d;
      iter_cnt_q   <= iter_cnt_d;
      stagger_q    <= stagger_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Buffer request and output composition
  ////////////////////////////////////////////////////////////

  // Inside a loop the whole body is freed at the end
  assign rb.raddr   = rd_ptr_q;
  assign rb.advance = active_q ? loop_end : seq_hs;
  assign rb.step    = active_q ? {1'b0, max_inst_q} + 1'b1 : (DepthBits+1)'(1);

  // Entry layout is argc above op
  assign {seq.argc, raw_op} = rb.rdata;

  // Stagger offset, modulo 32 per register field
  always_comb begin
    seq.op = raw_op;
    if (cfg_q.stagger_mask[0]) begin
      seq.op[frep_pkg::RdLsb +: 5] = raw_op[frep_pkg::RdLsb +: 5] + {2'b00, stagger_q};
    end
    if (cfg_q.stagger_mask[1]) begin
      seq.op[frep_pkg::Rs1Lsb +: 5] = raw_op[frep_pkg::Rs1Lsb +: 5] + {2'b00, stagger_q};
    end
    if (cfg_q.stagger_mask[2]) begin
      seq.op[frep_pkg::Rs2Lsb +: 5] = raw_op[frep_pkg::Rs2Lsb +: 5] + {2'b00, stagger_q};
    end
    if (cfg_q.stagger_mask[3]) begin
      seq.op[frep_pkg::Rs3Lsb +: 5] = raw_op[frep_pkg::Rs3Lsb +: 5] + {2'b00, stagger_q};
    end
  end

  assign seq.valid = rb.rvalid;
  // Any issue past the first iteration is a repeat
  assign seq.repd  = iter_cnt_q != '0;

endmodule

`default_nettype wire

// File: rtl/frep_pkg.sv
/*
 * FREP sequencer shared definitions
 * Widths, instruction path encoding, loop configuration and decode constants
 */
`default_nettype none

package frep_pkg;

  // Iteration count limited to 16 bits, i.e. up to 65536 iterations
  localparam int unsigned LoopIterBits = 16;
  localparam int unsigned InstWidth = 32;
  localparam int unsigned IdWidth = 5;

  // Where an offloaded instruction goes
  typedef enum logic [1:0] {
    PathBuffer = 2'd0,
    PathDirect = 2'd1,
    PathFrep   = 2'd2
  } inst_path_e;

  ////////////////////////////////////////////////////////////
  // Decode constants
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OpcodeFrep = 7'b0001011;
  localparam logic [6:0] OpcodeSystem = 7'b1110011;
  localparam logic [6:0] OpcodeOpFp = 7'b1010011;

  // OP-FP funct5 values that sync int and float pipelines
  localparam int unsigned NumDirectFunct5 = 5;
  localparam logic [NumDirectFunct5-1:0][4:0] DirectFunct5List = {
    5'b10100,  // compare
    5'b11000,  // convert to int
    5'b11010,  // convert from int
    5'b11100,  // move or classify to int
    5'b11110   // move from int
  };

  // FREP instruction field positions
  localparam int unsigned MaxInstLsb = 20;
  localparam int unsigned StaggerMaxLsb = 12;
  localparam int unsigned StaggerMaskLsb = 8;

  // Register fields, 5 bits each
  localparam int unsigned RdLsb = 7;
  localparam int unsigned Rs1Lsb = 15;
  localparam int unsigned Rs2Lsb = 20;
  localparam int unsigned Rs3Lsb = 27;

  // Loop configuration from decoder to loop controller
  typedef struct packed {
    logic [LoopIterBits-1:0] max_iter;
    logic [2:0]              stagger_max;
    logic [3:0]              stagger_mask;
  } frep_cfg_t;

endpackage

`default_nettype wire

// File: rtl/frep_ring_buffer.sv
/*
 * FREP ring buffer
 * Circular storage with write, base and random read pointers
 */
`timescale 1ns/1ps
`default_nettype none

module frep_ring_buffer #(
  parameter int unsigned Depth = 16,
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   wvalid_i,
  input  entry_t wdata_i,
  output logic   wready_o,
  frep_rb_if.buffer rb
);

  localparam int unsigned DepthBits = $clog2(Depth);

  // Write and base pointers with wrap bit
  logic [DepthBits:0] wptr_q;
  logic [DepthBits:0] base_q;
  logic [DepthBits:0] fill;
  logic [DepthBits-1:0] rd_offset;
  logic write;

  entry_t mem [Depth];

  ////////////////////////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////////////////////////

  assign fill     = wptr_q - base_q;
  assign wready_o = fill != (DepthBits+1)'(Depth);
  assign write    = wvalid_i && wready_o;

  // Read address is valid if it lies in [base, wptr)
  assign rd_offset = rb.raddr - base_q[DepthBits-1:0];
  assign rb.rvalid = {1'b0, rd_offset} < fill;

  assign rb.rdata = mem[rb.raddr];
  assign rb.wptr  = wptr_q[DepthBits-1:0];

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (write) begin
      mem[wptr_q[DepthBits-1:0]] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q <= '0;
      base_q <= '0;
    end else begin
      if (write) begin
        wptr_q <= wptr_q + 1'b1;
      end
      // Free entries once issued for good
      if (rb.advance) begin
        base_q <= base_q + rb.step;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/frep_sequencer.sv
/*
 * FREP instruction sequencer
 * Buffers and repeats offloaded FPU instructions between core and FPU
 */
`timescale 1ns/1ps
`default_nettype none

module frep_sequencer #(
  parameter int unsigned BufferDepth = 16,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // From the integer core
  input  logic [frep_pkg::IdWidth-1:0]   inp_qid_i,
  input  logic [frep_pkg::InstWidth-1:0] inp_qdata_op_i,
  input  logic [DataWidth-1:0]           inp_qdata_arga_i,
  input  logic [DataWidth-1:0]           inp_qdata_argb_i,
  input  logic [AddrWidth-1:0]           inp_qdata_argc_i,
  input  logic                           inp_qvalid_i,
  output logic                           inp_qready_o,
  // To the FPU
  output logic [frep_pkg::IdWidth-1:0]   oup_qid_o,
  output logic [frep_pkg::InstWidth-1:0] oup_qdata_op_o,
  output logic [DataWidth-1:0]           oup_qdata_arga_o,
  output logic [DataWidth-1:0]           oup_qdata_argb_o,
  output logic [AddrWidth-1:0]           oup_qdata_argc_o,
  output logic                           oup_qdata_repd_o,
  output logic                           oup_qvalid_o,
  input  logic                           oup_qready_i
);

  localparam int unsigned DepthBits = $clog2(BufferDepth);

  // Buffer entry, argc above op
  typedef struct packed {
    logic [AddrWidth-1:0]           argc;
    logic [frep_pkg::InstWidth-1:0] op;
  } rb_entry_t;

  logic rb_wvalid, rb_wready;
  logic frep_valid, frep_ready;
  logic direct_valid, direct_ready;
  frep_pkg::frep_cfg_t dec_cfg;
  frep_pkg::frep_cfg_t frep_cfg;
  logic [DepthBits-1:0] frep_max_inst;
  rb_entry_t rb_wdata;

  frep_rb_if #(.DepthBits(DepthBits), .EntryWidth($bits(rb_entry_t))) rb_if ();
  frep_seq_if #(.AddrWidth(AddrWidth)) seq_if ();

  ////////////////////////////////////////////////////////////
  // Decode and buffer
  ////////////////////////////////////////////////////////////

  frep_decoder frep_decoder_inst (
    .inp_qdata_op_i (inp_qdata_op_i),
    .inp_qvalid_i   (inp_qvalid_i),
    .inp_qready_o   (inp_qready_o),
    .rb_wvalid_o    (rb_wvalid),
    .rb_wready_i    (rb_wready),
    .frep_valid_o   (frep_valid),
    .frep_ready_i   (frep_ready),
    .frep_cfg_o     (dec_cfg),
    .direct_valid_o (direct_valid),
    .direct_ready_i (direct_ready)
  );

  // Iteration count travels in arga
  assign frep_cfg.max_iter     = inp_qdata_arga_i[frep_pkg::LoopIterBits-1:0];
  assign frep_cfg.stagger_max  = dec_cfg.stagger_max;
  assign frep_cfg.stagger_mask = dec_cfg.stagger_mask;
  assign frep_max_inst         = inp_qdata_op_i[frep_pkg::MaxInstLsb +: DepthBits];

  assign rb_wdata.argc = inp_qdata_argc_i;
  assign rb_wdata.op   = inp_qdata_op_i;

  frep_ring_buffer #(
    .Depth   (BufferDepth),
    .entry_t (rb_entry_t)
  ) frep_ring_buffer_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wvalid_i (rb_wvalid),
    .wdata_i  (rb_wdata),
    .wready_o (rb_wready),
    .rb       (rb_if.buffer)
  );

  ////////////////////////////////////////////////////////////
  // Loop control and issue
  ////////////////////////////////////////////////////////////

  frep_loop_ctrl #(.DepthBits(DepthBits)) frep_loop_ctrl_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .frep_valid_i    (frep_valid),
    .frep_cfg_i      (frep_cfg),
    .frep_max_inst_i (frep_max_inst),
    .frep_ready_o    (frep_ready),
    .rb              (rb_if.ctrl),
    .seq             (seq_if.src)
  );

  frep_issue_mux #(
    .DataWidth (DataWidth),
    .AddrWidth (AddrWidth)
  ) frep_issue_mux_inst (
    .seq              (seq_if.dst),
    .direct_valid_i   (direct_valid),
    .direct_ready_o   (direct_ready),
    .inp_qid_i        (inp_qid_i),
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argb_i (inp_qdata_argb_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .oup_qid_o        (oup_qid_o),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qdata_repd_o (oup_qdata_repd_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the FREP sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_frep_sequencer \
  -f verilog.f \
  -o sim_frep_sequencer

# The log decides the result, the simulator status may be lost in the pipe
./obj_dir/sim_frep_sequencer | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verilog.f
rtl/frep_pkg.sv
rtl/frep_if.sv
rtl/frep_decoder.sv
rtl/frep_ring_buffer.sv
rtl/frep_loop_ctrl.sv
rtl/frep_issue_mux.sv
rtl/frep_sequencer.sv
bench/frep_sequencer_sva.sv
bench/tb_frep_sequencer.sv
